// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP := tb_top
FILELIST := filelist.f
BUILD_DIR := obj_dir
SIM := $(BUILD_DIR)/V$(TOP)
LOG := sim.log
PASS_TEXT := test passed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
verilog/issue_pkg.sv
verilog/rv_decoder.sv
verilog/issue_queue.sv
verilog/issue_stage.sv
verilog/dual_issue_top.sv
verif/issue_checker.sv
verif/tb_top.sv

// ==== verif/issue_checker.sv ====
`timescale 1ns/100ps

module issue_checker (
  input logic clock,
  input logic reset,
  input logic [31:0] word0,
  input logic [31:0] word1,
  input logic word_valid0,
  input logic word_valid1,
  input logic clear,
  input logic stall,
  input logic fetch_stall,
  input logic lane0_valid,
  input issue_pkg::unit_type lane0_unit,
  input logic [4:0] lane0_rd,
  input logic [4:0] lane0_rs1,
  input logic [4:0] lane0_rs2,
  input logic [31:0] lane0_word,
  input logic lane1_valid,
  input issue_pkg::unit_type lane1_unit,
  input logic [4:0] lane1_rd,
  input logic [4:0] lane1_rs1,
  input logic [4:0] lane1_rs2,
  input logic [31:0] lane1_word,
  input logic swap
);

  logic [31:0] model_q [$];  // waiting words, oldest first.
  logic [31:0] exp_word [2];
  logic exp_valid [2];
  logic exp_swap = 1'b0;
  logic exp_fetch_stall = 1'b0;
  logic primed = 1'b0;
  int test_errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;

  function automatic issue_pkg::unit_type unit_of(input logic [31:0] w);
    case (w[6:0])
      issue_pkg::opcode_op_imm, issue_pkg::opcode_lui, issue_pkg::opcode_auipc:
        return issue_pkg::unit_alu;
      issue_pkg::opcode_op:
        return (w[31:25] == 7'b0000001) ? issue_pkg::unit_muldiv : issue_pkg::unit_alu;
      issue_pkg::opcode_jal, issue_pkg::opcode_jalr, issue_pkg::opcode_branch:
        return issue_pkg::unit_branch;
      issue_pkg::opcode_load, issue_pkg::opcode_store, issue_pkg::opcode_fload,
      issue_pkg::opcode_fstore:
        return issue_pkg::unit_mem;
      issue_pkg::opcode_misc_mem:
        return issue_pkg::unit_system;
      issue_pkg::opcode_system: begin
        if (w[14:12] != 3'b000) return issue_pkg::unit_system;
        if (w[31:20] inside {12'h000, 12'h001, 12'h302, 12'h105}) return issue_pkg::unit_system;
        return issue_pkg::unit_none;
      end
      default: return issue_pkg::unit_none;  // unknown words never enter.
    endcase
  endfunction

  function automatic logic is_basic(input logic [31:0] w);
    return unit_of(w) inside {issue_pkg::unit_alu, issue_pkg::unit_branch};
  endfunction

  function automatic logic writes_rd(input logic [31:0] w);
    logic hit;
    hit = w[6:0] inside {issue_pkg::opcode_lui, issue_pkg::opcode_auipc, issue_pkg::opcode_jal,
                         issue_pkg::opcode_jalr, issue_pkg::opcode_load, issue_pkg::opcode_op_imm,
                         issue_pkg::opcode_op};
    hit = hit | ((w[6:0] == issue_pkg::opcode_system) & (w[14:12] != 3'b000));
    return hit & (w[11:7] != 5'd0);
  endfunction

  function automatic logic reads_rs1(input logic [31:0] w);
    logic hit;
    hit = w[6:0] inside {issue_pkg::opcode_jalr, issue_pkg::opcode_branch, issue_pkg::opcode_load,
                         issue_pkg::opcode_store, issue_pkg::opcode_fload,
                         issue_pkg::opcode_fstore, issue_pkg::opcode_op_imm, issue_pkg::opcode_op};
    return hit | ((w[6:0] == issue_pkg::opcode_system) & (w[14:12] inside {3'b001, 3'b010, 3'b011}));
  endfunction

  function automatic logic reads_rs2(input logic [31:0] w);
    return w[6:0] inside {issue_pkg::opcode_branch, issue_pkg::opcode_store, issue_pkg::opcode_op};
  endfunction

  // how many of the two oldest words leave this cycle.
  function automatic int issue_count(input logic [31:0] a, input logic [31:0] b,
                                     input int size, input logic hold);
    logic conflict;
    conflict = writes_rd(a) & ((reads_rs1(b) & (b[19:15] == a[11:7])) |
                               (reads_rs2(b) & (b[24:20] == a[11:7])));
    if (hold || size == 0) return 0;
    if (size == 1) return 1;
    if ((is_basic(a) || is_basic(b)) && !conflict) return 2;
    return 1;
  endfunction

  always @(posedge clock) begin
    int n;
    logic [31:0] a;
    logic [31:0] b;
    exp_word[0] = '0;
    exp_word[1] = '0;
    exp_valid[0] = 1'b0;
    exp_valid[1] = 1'b0;
    exp_swap = 1'b0;
    if (!reset) begin
      model_q.delete();
      exp_fetch_stall = 1'b0;
    end else begin
      if (clear) begin
        model_q.delete();
      end else if (!exp_fetch_stall) begin
        if (word_valid0 && unit_of(word0) != issue_pkg::unit_none) model_q.push_back(word0);
        if (word_valid1 && unit_of(word1) != issue_pkg::unit_none) model_q.push_back(word1);
      end
      a = (model_q.size() > 0) ? model_q[0] : '0;
      b = (model_q.size() > 1) ? model_q[1] : '0;
      n = issue_count(a, b, model_q.size(), stall);
      if (n > 0) begin
        exp_valid[0] = 1'b1;
        exp_word[0] = a;
      end
      if (n == 2) begin
        exp_valid[1] = 1'b1;
        exp_word[1] = b;
        exp_swap = is_basic(a) & ~is_basic(b);
        if (exp_swap) begin
          exp_word[0] = b;  // complex word takes lane 0.
          exp_word[1] = a;
        end
      end
      repeat (n) void'(model_q.pop_front());
      exp_fetch_stall = model_q.size() > issue_pkg::stall_level;
    end
    primed = 1'b1;
  end

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic compare_lane(input string lane, input int idx, input logic act_valid,
                              input logic [2:0] act_unit, input logic [4:0] act_rd,
                              input logic [4:0] act_rs1, input logic [4:0] act_rs2,
                              input logic [31:0] act_word);
    logic [31:0] w;
    w = exp_word[idx];  // all zero on an idle lane.
    compare_value({lane, "_valid"}, 32'(exp_valid[idx]), 32'(act_valid));
    compare_value({lane, "_unit"}, 32'(unit_of(w)), 32'(act_unit));
    compare_value({lane, "_rd"}, 32'(w[11:7]), 32'(act_rd));
    compare_value({lane, "_rs1"}, 32'(w[19:15]), 32'(act_rs1));
    compare_value({lane, "_rs2"}, 32'(w[24:20]), 32'(act_rs2));
    compare_value({lane, "_word"}, w, act_word);
  endtask

  always @(negedge clock) begin
    if (primed) begin
      compare_value("fetch_stall", 32'(exp_fetch_stall), 32'(fetch_stall));
      compare_value("swap", 32'(exp_swap), 32'(swap));
      compare_lane("lane0", 0, lane0_valid, lane0_unit, lane0_rd, lane0_rs1, lane0_rs2,
                   lane0_word);
      compare_lane("lane1", 1, lane1_valid, lane1_unit, lane1_rd, lane1_rs1, lane1_rs2,
                   lane1_word);
    end
  end

  task automatic end_test(input string name);
    if (test_errors == 0) begin
      tests_passed++;
      $display("%s: ok", name);
    end else begin
      tests_failed++;
      $display("%s: %0d mismatches", name, test_errors);
    end
    test_errors = 0;
  endtask

  task automatic print_totals();
    $display("tests run %0d, ok %0d, failing %0d", tests_passed + tests_failed, tests_passed,
             tests_failed);
  endtask

endmodule

// ==== verif/tb_top.sv ====
`timescale 1ns/100ps

module tb_top;

  logic clock;
  logic reset;
  logic [31:0] word0;
  logic [31:0] word1;
  logic word_valid0;
  logic word_valid1;
  logic clear;
  logic stall;
  logic fetch_stall;
  logic lane0_valid;
  issue_pkg::unit_type lane0_unit;
  logic [4:0] lane0_rd;
  logic [4:0] lane0_rs1;
  logic [4:0] lane0_rs2;
  logic [31:0] lane0_word;
  logic lane1_valid;
  issue_pkg::unit_type lane1_unit;
  logic [4:0] lane1_rd;
  logic [4:0] lane1_rs1;
  logic [4:0] lane1_rs2;
  logic [31:0] lane1_word;
  logic swap;
  logic timed_out = 1'b0;

  dual_issue_top dual_issue_top_i (.*);

  issue_checker issue_checker_i (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  initial begin
    @(posedge timed_out);
    $display("test failed");
    $finish;
  end

  function automatic logic [31:0] i_word(input logic [6:0] opcode, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, opcode};
  endfunction

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, issue_pkg::opcode_op};
  endfunction

  // store and branch shapes with a zero immediate.
  function automatic logic [31:0] s_word(input logic [6:0] opcode, input logic [2:0] f3,
                                         input logic [4:0] rs1, input logic [4:0] rs2);
    return {7'd0, rs2, rs1, f3, 5'd0, opcode};
  endfunction

  function automatic logic [31:0] random_word();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [31:0] w;
    rd = 5'($urandom_range(0, 7));  // few registers make hazards common.
    rs1 = 5'($urandom_range(0, 7));
    rs2 = 5'($urandom_range(0, 7));
    case ($urandom_range(0, 7))
      0: w = i_word(issue_pkg::opcode_op_imm, 3'b000, rd, rs1, 12'h001);
      1: w = r_word(7'b0000000, 3'b000, rd, rs1, rs2);
      2: w = s_word(issue_pkg::opcode_branch, 3'b000, rs1, rs2);
      3: w = i_word(issue_pkg::opcode_load, 3'b010, rd, rs1, 12'h000);
      4: w = s_word(issue_pkg::opcode_store, 3'b010, rs1, rs2);
      5: w = r_word(7'b0000001, 3'b000, rd, rs1, rs2);
      6: w = i_word(issue_pkg::opcode_system, 3'b001, rd, rs1, 12'h300);
      default: w = 32'h00000073;  // ecall.
    endcase
    return w;
  endfunction

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic report_timeout(input string what);
    $display("timeout: %s within 200 cycles", what);
    timed_out = 1'b1;
    forever @(posedge clock);
  endtask

  // hold the pair until the queue takes it.
  task automatic feed(input logic [31:0] w0, input logic [31:0] w1);
    int waited;
    word0 = w0;
    word1 = w1;
    word_valid0 = 1'b1;
    word_valid1 = 1'b1;
    waited = 0;
    while (fetch_stall && waited < 200) begin
      step();
      waited++;
    end
    if (fetch_stall) report_timeout("fetch_stall did not fall");
    step();
    word_valid0 = 1'b0;
    word_valid1 = 1'b0;
  endtask

  task automatic drain();
    int idle;
    int waited;
    stall = 1'b0;
    word_valid0 = 1'b0;
    word_valid1 = 1'b0;
    idle = 0;
    waited = 0;
    while (idle < 3 && waited < 200) begin
      step();
      waited++;
      idle = (lane0_valid || lane1_valid || fetch_stall) ? 0 : idle + 1;
    end
    if (idle < 3) report_timeout("lanes did not go idle");
  endtask

  task automatic random_run(input int cycles);
    logic held;
    held = 1'b0;
    for (int i = 0; i < cycles; i++) begin
      if (!held) begin
        word0 = random_word();
        word1 = random_word();
        word_valid0 = $urandom_range(0, 3) != 0;
        word_valid1 = $urandom_range(0, 3) != 0;
      end
      held = fetch_stall & (word_valid0 | word_valid1);  // refused at the next edge.
      stall = $urandom_range(0, 3) == 0;
      clear = $urandom_range(0, 31) == 0;
      step();
    end
    clear = 1'b0;
    drain();
  endtask

  initial begin
    void'($urandom(32'h4b6ad832));
    reset = 1'b0;
    word0 = '0;
    word1 = '0;
    word_valid0 = 1'b0;
    word_valid1 = 1'b0;
    clear = 1'b0;
    stall = 1'b0;
    repeat (2) step();
    reset = 1'b1;
    step();

    feed(i_word(issue_pkg::opcode_op_imm, 3'b000, 5'd1, 5'd0, 12'h001),
         i_word(issue_pkg::opcode_op_imm, 3'b000, 5'd2, 5'd0, 12'h002));
    drain();
    issue_checker_i.end_test("alu pair");

    feed(i_word(issue_pkg::opcode_op_imm, 3'b000, 5'd5, 5'd0, 12'h001),
         i_word(issue_pkg::opcode_op_imm, 3'b000, 5'd6, 5'd5, 12'h002));
    drain();
    issue_checker_i.end_test("raw hazard");

    feed(i_word(issue_pkg::opcode_op_imm, 3'b000, 5'd1, 5'd0, 12'h003),
         i_word(issue_pkg::opcode_load, 3'b010, 5'd7, 5'd2, 12'h000));
    drain();
    issue_checker_i.end_test("alu with load swap");

    feed(i_word(issue_pkg::opcode_load, 3'b010, 5'd1, 5'd2, 12'h000),
         i_word(issue_pkg::opcode_load, 3'b010, 5'd3, 5'd4, 12'h004));
    feed(r_word(7'b0000001, 3'b000, 5'd5, 5'd6, 5'd7),
         i_word(issue_pkg::opcode_system, 3'b001, 5'd8, 5'd9, 12'h300));
    drain();
    issue_checker_i.end_test("complex pairs");

    stall = 1'b1;
    for (int i = 0; i < 3; i++) begin
      feed(i_word(issue_pkg::opcode_op_imm, 3'b000, 5'(2 * i + 1), 5'd0, 12'(i)),
           i_word(issue_pkg::opcode_op_imm, 3'b000, 5'(2 * i + 2), 5'd0, 12'(i)));
    end
    repeat (4) step();  // fetch_stall up and lanes idle.
    stall = 1'b0;
    feed(r_word(7'b0000000, 3'b000, 5'd10, 5'd1, 5'd2),
         i_word(issue_pkg::opcode_store, 3'b010, 5'd3, 5'd4, 12'h000));
    drain();
    issue_checker_i.end_test("stall backpressure");

    stall = 1'b1;
    feed(random_word(), random_word());
    feed(random_word(), random_word());
    clear = 1'b1;
    stall = 1'b0;
    step();
    clear = 1'b0;
    feed(i_word(issue_pkg::opcode_op_imm, 3'b000, 5'd1, 5'd0, 12'h001),
         s_word(issue_pkg::opcode_branch, 3'b000, 5'd1, 5'd3));
    drain();
    issue_checker_i.end_test("clear flush");

    random_run(400);
    issue_checker_i.end_test("random mix");

    issue_checker_i.print_totals();
    if (issue_checker_i.tests_failed == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== verilog/dual_issue_top.sv ====
`timescale 1ns/100ps

module dual_issue_top (
  input logic clock,
  input logic reset,
  input logic [31:0] word0,
  input logic [31:0] word1,
  input logic word_valid0,
  input logic word_valid1,
  input logic clear,
  input logic stall,
  output logic fetch_stall,
  output logic lane0_valid,
  output issue_pkg::unit_type lane0_unit,
  output logic [4:0] lane0_rd,
  output logic [4:0] lane0_rs1,
  output logic [4:0] lane0_rs2,
  output logic [31:0] lane0_word,
  output logic lane1_valid,
  output issue_pkg::unit_type lane1_unit,
  output logic [4:0] lane1_rd,
  output logic [4:0] lane1_rs1,
  output logic [4:0] lane1_rs2,
  output logic [31:0] lane1_word,
  output logic swap
);

  issue_pkg::instruction_type instr0;
  issue_pkg::instruction_type instr1;
  issue_pkg::instruction_type issue0;
  issue_pkg::instruction_type issue1;
  logic issue_swap;

  rv_decoder rv_decoder0_i (
    .word(word0),
    .word_valid(word_valid0),
    .instr(instr0)
  );

  rv_decoder rv_decoder1_i (
    .word(word1),
    .word_valid(word_valid1),
    .instr(instr1)
  );

  issue_queue issue_queue_i (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .stall(stall),
    .instr0(instr0),
    .instr1(instr1),
    .issue0(issue0),
    .issue1(issue1),
    .swap(issue_swap),
    .fetch_stall(fetch_stall)
  );

  issue_stage issue_stage_i (
    .clock(clock),
    .reset(reset),
    .clear(clear),
    .issue0(issue0),
    .issue1(issue1),
    .swap_in(issue_swap),
    .lane0_valid(lane0_valid),
    .lane1_valid(lane1_valid),
    .swap(swap),
    .lane0_unit(lane0_unit),
    .lane1_unit(lane1_unit),
    .lane0_rd(lane0_rd),
    .lane0_rs1(lane0_rs1),
    .lane0_rs2(lane0_rs2),
    .lane1_rd(lane1_rd),
    .lane1_rs1(lane1_rs1),
    .lane1_rs2(lane1_rs2),
    .lane0_word(lane0_word),
    .lane1_word(lane1_word)
  );

endmodule

// ==== verilog/issue_pkg.sv ====
package issue_pkg;

  // queue geometry.
  localparam int queue_depth = 8;
  localparam int queue_ptr_width = 3;
  localparam int queue_count_width = queue_ptr_width + 1;
  localparam int stall_level = 4;  // fetch held above this occupancy.

  // rv32 major opcodes.
  localparam logic [6:0] opcode_lui = 7'b0110111;
  localparam logic [6:0] opcode_auipc = 7'b0010111;
  localparam logic [6:0] opcode_jal = 7'b1101111;
  localparam logic [6:0] opcode_jalr = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_load = 7'b0000011;
  localparam logic [6:0] opcode_store = 7'b0100011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_op = 7'b0110011;
  localparam logic [6:0] opcode_misc_mem = 7'b0001111;
  localparam logic [6:0] opcode_system = 7'b1110011;
  localparam logic [6:0] opcode_fload = 7'b0000111;
  localparam logic [6:0] opcode_fstore = 7'b0100111;

  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // privileged encodings under system with funct3 zero.
  localparam logic [11:0] funct12_ecall = 12'h000;
  localparam logic [11:0] funct12_ebreak = 12'h001;
  localparam logic [11:0] funct12_mret = 12'h302;
  localparam logic [11:0] funct12_wfi = 12'h105;

  typedef struct packed {
    logic valid;
    logic alu;
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic mult;
    logic division;
    logic csreg;
    logic fence;
    logic ecall;
    logic ebreak;
    logic mret;
    logic wfi;
    logic wren;
    logic rden1;
    logic rden2;
  } op_type;

  typedef struct packed {
    op_type op;
    logic [4:0] waddr;
    logic [4:0] raddr1;
    logic [4:0] raddr2;
    logic [31:0] word;
  } instruction_type;

  localparam instruction_type init_instruction = '0;

  typedef enum logic [2:0] {
    unit_none,
    unit_alu,
    unit_branch,
    unit_mem,
    unit_muldiv,
    unit_system
  } unit_type;

endpackage

// ==== verilog/issue_queue.sv ====
`timescale 1ns/100ps

module issue_queue (
  input logic clock,
  input logic reset,
  input logic clear,
  input logic stall,
  input issue_pkg::instruction_type instr0,
  input issue_pkg::instruction_type instr1,
  output issue_pkg::instruction_type issue0,
  output issue_pkg::instruction_type issue1,
  output logic swap,
  output logic fetch_stall
);

  localparam int ptr_w = issue_pkg::queue_ptr_width;
  localparam int cnt_w = issue_pkg::queue_count_width;

  issue_pkg::instruction_type mem [issue_pkg::queue_depth];

  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] wr_ptr_1;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w-1:0] rd_ptr_1;
  logic [cnt_w-1:0] count;
  logic [cnt_w-1:0] base;
  logic [cnt_w-1:0] avail;
  logic [cnt_w-1:0] count_next;
  logic accept;
  logic [1:0] n_in;
  logic [1:0] pass;
  issue_pkg::instruction_type first;
  issue_pkg::instruction_type second;
  issue_pkg::instruction_type rec_a;
  issue_pkg::instruction_type rec_b;
  logic basic_a;
  logic basic_b;
  logic complex_a;
  logic complex_b;
  logic pair_ok;
  logic hazard;

  function automatic logic is_basic(input issue_pkg::op_type op);
    return op.alu | op.lui | op.auipc | op.jal | op.jalr | op.branch;
  endfunction

  function automatic logic is_complex(input issue_pkg::op_type op);
    logic hit;
    hit = op.load | op.store | op.mult | op.division | op.csreg;
    hit = hit | op.fence | op.ecall | op.ebreak | op.mret | op.wfi;
    return hit;
  endfunction

  assign accept = ~clear & ~fetch_stall;
  assign n_in = accept ? {1'b0, instr0.op.valid} + {1'b0, instr1.op.valid} : 2'd0;
  assign first = instr0.op.valid ? instr0 : instr1;  // packs a lone valid record.
  assign second = instr1;

  assign wr_ptr_1 = wr_ptr + ptr_w'(1);
  assign rd_ptr_1 = rd_ptr + ptr_w'(1);

  assign base = clear ? '0 : count;
  assign avail = base + cnt_w'(n_in);

  // oldest two records with this cycle's writes bypassed.
  always_comb begin
    if (base != '0) begin
      rec_a = mem[rd_ptr];
    end else if (n_in != 2'd0) begin
      rec_a = first;
    end else begin
      rec_a = issue_pkg::init_instruction;
    end
    if (base > cnt_w'(1)) begin
      rec_b = mem[rd_ptr_1];
    end else if (base == cnt_w'(1)) begin
      rec_b = (n_in != 2'd0) ? first : issue_pkg::init_instruction;
    end else begin
      rec_b = (n_in == 2'd2) ? second : issue_pkg::init_instruction;
    end
  end

  assign basic_a = is_basic(rec_a.op);
  assign basic_b = is_basic(rec_b.op);
  assign complex_a = is_complex(rec_a.op);
  assign complex_b = is_complex(rec_b.op);

  assign pair_ok = (basic_a & basic_b) | (basic_a & complex_b) | (complex_a & basic_b);
  assign hazard = rec_a.op.wren &
                  ((rec_b.op.rden1 & (rec_b.raddr1 == rec_a.waddr)) |
                   (rec_b.op.rden2 & (rec_b.raddr2 == rec_a.waddr)));

  always_comb begin
    if (stall) begin
      pass = 2'd0;
    end else if (pair_ok & ~hazard) begin
      pass = 2'd2;
    end else begin
      pass = 2'd1;
    end
    if (avail < cnt_w'(pass)) begin
      pass = avail[1:0];  // capped by occupancy.
    end
  end

  assign swap = (pass == 2'd2) & basic_a & complex_b;  // complex record goes to lane 0.
  assign issue0 = (pass == 2'd0) ? issue_pkg::init_instruction : (swap ? rec_b : rec_a);
  assign issue1 = (pass == 2'd2) ? (swap ? rec_a : rec_b) : issue_pkg::init_instruction;

  assign count_next = avail - cnt_w'(pass);

  always_ff @(posedge clock) begin
    if (!reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      fetch_stall <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr + ptr_w'(n_in);
      rd_ptr <= clear ? wr_ptr : rd_ptr + ptr_w'(pass);  // empty queue restarts at the write slot.
      count <= count_next;
      fetch_stall <= count_next > cnt_w'(issue_pkg::stall_level);
    end
  end

  always_ff @(posedge clock) begin
    if (n_in != 2'd0) begin
      mem[wr_ptr] <= first;
    end
    if (n_in == 2'd2) begin
      mem[wr_ptr_1] <= second;
    end
  end

  count_bound: assert property (@(posedge clock) disable iff (!reset)
    count <= cnt_w'(issue_pkg::queue_depth));

  lane_order: assert property (@(posedge clock) disable iff (!reset)
    issue1.op.valid |-> issue0.op.valid);

endmodule

// ==== verilog/issue_stage.sv ====
`timescale 1ns/100ps

module issue_stage (
  input logic clock,
  input logic reset,
  input logic clear,
  input issue_pkg::instruction_type issue0,
  input issue_pkg::instruction_type issue1,
  input logic swap_in,
  output logic lane0_valid,
  output logic lane1_valid,
  output logic swap,
  output issue_pkg::unit_type lane0_unit,
  output issue_pkg::unit_type lane1_unit,
  output logic [4:0] lane0_rd,
  output logic [4:0] lane0_rs1,
  output logic [4:0] lane0_rs2,
  output logic [4:0] lane1_rd,
  output logic [4:0] lane1_rs1,
  output logic [4:0] lane1_rs2,
  output logic [31:0] lane0_word,
  output logic [31:0] lane1_word
);

  function automatic issue_pkg::unit_type unit_of(input issue_pkg::op_type op);
    issue_pkg::unit_type unit;
    unit = issue_pkg::unit_none;
    if (op.alu | op.lui | op.auipc) begin
      unit = issue_pkg::unit_alu;
    end else if (op.jal | op.jalr | op.branch) begin
      unit = issue_pkg::unit_branch;
    end else if (op.load | op.store) begin
      unit = issue_pkg::unit_mem;
    end else if (op.mult | op.division) begin
      unit = issue_pkg::unit_muldiv;
    end else if (op.csreg | op.fence | op.ecall | op.ebreak | op.mret | op.wfi) begin
      unit = issue_pkg::unit_system;
    end
    return op.valid ? unit : issue_pkg::unit_none;
  endfunction

  always_ff @(posedge clock) begin
    if (!reset || clear) begin
      lane0_valid <= 1'b0;
      lane1_valid <= 1'b0;
      swap <= 1'b0;
      lane0_unit <= issue_pkg::unit_none;
      lane1_unit <= issue_pkg::unit_none;
      lane0_rd <= '0;
      lane0_rs1 <= '0;
      lane0_rs2 <= '0;
      lane1_rd <= '0;
      lane1_rs1 <= '0;
      lane1_rs2 <= '0;
      lane0_word <= '0;
      lane1_word <= '0;
    end else begin
      lane0_valid <= issue0.op.valid;
      lane1_valid <= issue1.op.valid;
      swap <= swap_in;
      lane0_unit <= unit_of(issue0.op);
      lane1_unit <= unit_of(issue1.op);
      lane0_rd <= issue0.waddr;
      lane0_rs1 <= issue0.raddr1;
      lane0_rs2 <= issue0.raddr2;
      lane1_rd <= issue1.waddr;
      lane1_rs1 <= issue1.raddr1;
      lane1_rs2 <= issue1.raddr2;
      lane0_word <= issue0.word;
      lane1_word <= issue1.word;
    end
  end

  // every decoded class must land on a real unit.
  lane0_unit_known: assert property (@(posedge clock) disable iff (!reset)
    lane0_valid |-> lane0_unit != issue_pkg::unit_none);

  lane1_unit_known: assert property (@(posedge clock) disable iff (!reset)
    lane1_valid |-> lane1_unit != issue_pkg::unit_none);

endmodule

// ==== verilog/rv_decoder.sv ====
`timescale 1ns/100ps

module rv_decoder (
  input logic [31:0] word,
  input logic word_valid,
  output issue_pkg::instruction_type instr
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [11:0] funct12;
  logic known;
  issue_pkg::op_type op;

  assign opcode = word[6:0];
  assign funct3 = word[14:12];
  assign funct7 = word[31:25];
  assign funct12 = word[31:20];

  always_comb begin
    op = '0;
    case (opcode)
      issue_pkg::opcode_lui: begin
        op.lui = 1'b1;
        op.wren = 1'b1;
      end
      issue_pkg::opcode_auipc: begin
        op.auipc = 1'b1;
        op.wren = 1'b1;
      end
      issue_pkg::opcode_jal: begin
        op.jal = 1'b1;
        op.wren = 1'b1;
      end
      issue_pkg::opcode_jalr: begin
        op.jalr = 1'b1;
        op.wren = 1'b1;
        op.rden1 = 1'b1;
      end
      issue_pkg::opcode_branch: begin
        op.branch = 1'b1;
        op.rden1 = 1'b1;
        op.rden2 = 1'b1;
      end
      issue_pkg::opcode_load: begin
        op.load = 1'b1;
        op.wren = 1'b1;
        op.rden1 = 1'b1;
      end
      issue_pkg::opcode_store: begin
        op.store = 1'b1;
        op.rden1 = 1'b1;
        op.rden2 = 1'b1;
      end
      issue_pkg::opcode_fload: begin
        op.load = 1'b1;  // float rd, only the base is integer.
        op.rden1 = 1'b1;
      end
      issue_pkg::opcode_fstore: begin
        op.store = 1'b1;
        op.rden1 = 1'b1;
      end
      issue_pkg::opcode_op_imm: begin
        op.alu = 1'b1;
        op.wren = 1'b1;
        op.rden1 = 1'b1;
      end
      issue_pkg::opcode_op: begin
        if (funct7 == issue_pkg::funct7_muldiv) begin
          op.mult = ~funct3[2];
          op.division = funct3[2];
        end else begin
          op.alu = 1'b1;
        end
        op.wren = 1'b1;
        op.rden1 = 1'b1;
        op.rden2 = 1'b1;
      end
      issue_pkg::opcode_misc_mem: begin
        op.fence = 1'b1;  // fence and fence.i.
      end
      issue_pkg::opcode_system: begin
        if (funct3 != 3'b000) begin
          op.csreg = 1'b1;
          op.wren = 1'b1;
          op.rden1 = ~funct3[2];  // immediate forms read no register.
        end else begin
          case (funct12)
            issue_pkg::funct12_ecall: op.ecall = 1'b1;
            issue_pkg::funct12_ebreak: op.ebreak = 1'b1;
            issue_pkg::funct12_mret: op.mret = 1'b1;
            issue_pkg::funct12_wfi: op.wfi = 1'b1;
            default: op.ecall = 1'b0;
          endcase
        end
      end
      default: op.alu = 1'b0;  // other float opcodes dropped.
    endcase
    known = op.alu | op.lui | op.auipc | op.jal | op.jalr | op.branch;
    known = known | op.load | op.store | op.mult | op.division | op.csreg;
    known = known | op.fence | op.ecall | op.ebreak | op.mret | op.wfi;
    op.valid = word_valid & known;
    op.wren = op.wren & (word[11:7] != 5'd0);  // x0 is never written.
  end

  always_comb begin
    if (op.valid) begin
      instr.op = op;
      instr.waddr = word[11:7];
      instr.raddr1 = word[19:15];
      instr.raddr2 = word[24:20];
      instr.word = word;
    end else begin
      instr = issue_pkg::init_instruction;
    end
  end

endmodule
